/* hdl/frontend_defs.svh */
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// First fetch address out of reset
`define FE_RESET_PC 32'h6000_0000

// One cache line per fetch
`define FE_LINE_BITS 256

// RV32I words per line
`define FE_LANES 8

// Entries offered to the consumer each cycle
`define FE_ISSUE 2

// Instruction queue entries
// Must stay a power of two so the pointers wrap on their own
`define FE_IQ_DEPTH 32

`endif

/* hdl/frontend_pkg.sv */
package frontend_pkg;

// Register-register layout
typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
} r_fmt_t;

// Immediate, load and jalr layout
typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
} i_fmt_t;

// Store and branch share the split immediate
typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
} sb_fmt_t;

// Upper immediate and jal layout
typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
} uj_fmt_t;

// One instruction word seen through every format
typedef union packed {
    r_fmt_t  r;
    i_fmt_t  i;
    sb_fmt_t sb;
    uj_fmt_t uj;
} inst_word_u;

typedef enum logic [3:0] {
    OP_REG,
    OP_IMM,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH,
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_ILLEGAL
} op_class_e;

// What decode hands to the queue per lane
typedef struct packed {
    logic [31:0] pc;
    inst_word_u  inst;
    op_class_e   op_class;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
} decoded_inst_t;

endpackage : frontend_pkg

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module fetch_stage
(
    input   logic           clk,
    input   logic           rst_n,

    // Instruction memory side
    input   logic           imem_resp,
    output  logic   [31:0]  imem_addr,
    output  logic           imem_read,

    // Queue has space for two more lines
    input   logic           line_room,

    // Address of the line coming back, for decode
    output  logic   [31:0]  line_pc
);

// Pc step is one full line
localparam logic [31:0] LINE_BYTES = 32'(`FE_LINE_BITS / 8);

logic [31:0] pc_reg;
logic        pending;

// Pending flag doubles as the request level
// Starts only when idle and the queue reports room
// Clears on the response, pc moves to the next line in the same edge
always_ff @(posedge clk) begin
    if (!rst_n) begin
        pc_reg  <= `FE_RESET_PC;
        pending <= 1'b0;
    end else if (pending) begin
        if (imem_resp) begin
            pending <= 1'b0;
            pc_reg  <= pc_reg + LINE_BYTES;
        end
    end else if (line_room) begin
        pending <= 1'b1;
    end
end

// Address and level hold steady while pending
assign imem_addr = pc_reg;
assign imem_read = pending;

// Pc only moves after the response, so it still names the returning line
assign line_pc   = pc_reg;

endmodule : fetch_stage

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module decode_stage
import frontend_pkg::*;
(
    input   logic                       clk,
    input   logic                       rst_n,

    // Line straight from memory
    input   logic   [`FE_LINE_BITS-1:0] imem_rdata,
    input   logic                       imem_resp,
    input   logic   [31:0]              line_pc,

    // Registered lanes toward the queue
    output  decoded_inst_t              dec_entries [`FE_LANES],
    output  logic                       dec_valid
);

// RV32I base opcodes
localparam logic [6:0] OPC_REG    = 7'b0110011;
localparam logic [6:0] OPC_IMM    = 7'b0010011;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_JALR   = 7'b1100111;

function automatic decoded_inst_t decode_word(input logic [31:0] pc, input logic [31:0] word);
    decoded_inst_t d;
    inst_word_u    w;
    w = word;
    // Unused fields stay zero
    d = '0;
    d.pc   = pc;
    d.inst = w;
    // Opcode sits at the same place in every view
    case (w.r.opcode)
        OPC_REG:    d.op_class = OP_REG;
        OPC_IMM:    d.op_class = OP_IMM;
        OPC_LOAD:   d.op_class = OP_LOAD;
        OPC_STORE:  d.op_class = OP_STORE;
        OPC_BRANCH: d.op_class = OP_BRANCH;
        OPC_LUI:    d.op_class = OP_LUI;
        OPC_AUIPC:  d.op_class = OP_AUIPC;
        OPC_JAL:    d.op_class = OP_JAL;
        OPC_JALR:   d.op_class = OP_JALR;
        default:    d.op_class = OP_ILLEGAL;
    endcase
    case (d.op_class)
        OP_REG: begin
            d.rd  = w.r.rd;
            d.rs1 = w.r.rs1;
            d.rs2 = w.r.rs2;
        end
        // I format, 12-bit signed immediate
        OP_IMM, OP_LOAD, OP_JALR: begin
            d.rd  = w.i.rd;
            d.rs1 = w.i.rs1;
            d.imm = {{20{w.i.imm[11]}}, w.i.imm};
        end
        OP_STORE: begin
            d.rs1 = w.sb.rs1;
            d.rs2 = w.sb.rs2;
            d.imm = {{20{w.sb.imm_hi[6]}}, w.sb.imm_hi, w.sb.imm_lo};
        end
        // B format scrambles bits 11 and 12, offset is even
        OP_BRANCH: begin
            d.rs1 = w.sb.rs1;
            d.rs2 = w.sb.rs2;
            d.imm = {{19{w.sb.imm_hi[6]}}, w.sb.imm_hi[6], w.sb.imm_lo[0],
                     w.sb.imm_hi[5:0], w.sb.imm_lo[4:1], 1'b0};
        end
        // Upper 20 bits, low 12 zero
        OP_LUI, OP_AUIPC: begin
            d.rd  = w.uj.rd;
            d.imm = {w.uj.imm, 12'b0};
        end
        // J format, 21-bit signed even offset
        OP_JAL: begin
            d.rd  = w.uj.rd;
            d.imm = {{11{w.uj.imm[19]}}, w.uj.imm[19], w.uj.imm[7:0],
                     w.uj.imm[8], w.uj.imm[18:9], 1'b0};
        end
        default: begin
        end
    endcase
    return d;
endfunction

decoded_inst_t lane_dec [`FE_LANES];

// Word k sits at bits 32k+31:32k, pc steps by four per lane
for (genvar g = 0; g < `FE_LANES; g++) begin : g_lane
    assign lane_dec[g] = decode_word(line_pc + 32'(4 * g), imem_rdata[32*g +: 32]);
end

// Strobe one cycle behind the response
always_ff @(posedge clk) begin
    if (!rst_n) begin
        dec_valid <= 1'b0;
    end else begin
        dec_valid <= imem_resp;
    end
end

// Payload only loads on a response
always_ff @(posedge clk) begin
    if (imem_resp) begin
        dec_entries <= lane_dec;
    end
end

endmodule : decode_stage

/* hdl/inst_queue.sv */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module inst_queue
import frontend_pkg::*;
(
    input   logic                   clk,
    input   logic                   rst_n,

    // Eight-wide push from decode
    input   decoded_inst_t          dec_entries [`FE_LANES],
    input   logic                   dec_valid,

    // Consumer side
    input   logic                   issue_pop,
    output  decoded_inst_t          issue_inst [`FE_ISSUE],
    output  logic   [`FE_ISSUE-1:0] issue_valid,

    // Back-pressure toward fetch
    output  logic                   line_room
);

localparam int PTR_W = $clog2(`FE_IQ_DEPTH);
localparam int CNT_W = $clog2(`FE_IQ_DEPTH + 1);
localparam int POP_W = $clog2(`FE_ISSUE + 1);

// Room for the line in decode and the one in flight
localparam logic [CNT_W-1:0] ROOM_MIN = CNT_W'(2 * `FE_LANES);

decoded_inst_t    mem [`FE_IQ_DEPTH];
logic [PTR_W-1:0] head;
logic [PTR_W-1:0] tail;
logic [CNT_W-1:0] count;
logic [POP_W-1:0] pop_num;

// Lane i valid once more than i entries are held
// Oldest entries appear in order starting at head
always_comb begin
    for (int i = 0; i < `FE_ISSUE; i++) begin
        issue_valid[i] = count > CNT_W'(i);
        issue_inst[i]  = mem[head + PTR_W'(i)];
    end
end

// Pop takes every valid lane, nothing when empty
always_comb begin
    pop_num = '0;
    for (int i = 0; i < `FE_ISSUE; i++) begin
        if (issue_pop && issue_valid[i]) begin
            pop_num = pop_num + 1'b1;
        end
    end
end

// Pointers and occupancy
always_ff @(posedge clk) begin
    if (!rst_n) begin
        head  <= '0;
        tail  <= '0;
        count <= '0;
    end else begin
        head <= head + PTR_W'(pop_num);
        if (dec_valid) begin
            tail <= tail + PTR_W'(`FE_LANES);
        end
        count <= count + (dec_valid ? CNT_W'(`FE_LANES) : CNT_W'(0)) - CNT_W'(pop_num);
    end
end

// Whole line lands at tail, wraps with the pointer width
always_ff @(posedge clk) begin
    if (dec_valid) begin
        for (int k = 0; k < `FE_LANES; k++) begin
            mem[tail + PTR_W'(k)] <= dec_entries[k];
        end
    end
end

// Free count against two lines
assign line_room = (CNT_W'(`FE_IQ_DEPTH) - count) >= ROOM_MIN;

endmodule : inst_queue

/* hdl/front_end.sv */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module front_end
import frontend_pkg::*;
(
    input   logic                       clk,
    input   logic                       rst_n,

    // Instruction memory request port
    output  logic   [31:0]              imem_addr,
    output  logic                       imem_read,
    input   logic   [`FE_LINE_BITS-1:0] imem_rdata,
    input   logic                       imem_resp,

    // Consumer port
    output  decoded_inst_t              issue_inst [`FE_ISSUE],
    output  logic   [`FE_ISSUE-1:0]     issue_valid,
    input   logic                       issue_pop
);

// Fetch to decode
logic [31:0]   line_pc;
// Decode to queue
decoded_inst_t dec_entries [`FE_LANES];
logic          dec_valid;
// Queue back to fetch
logic          line_room;

fetch_stage fetch_stage_i (
    .clk(clk), .rst_n(rst_n),
    .imem_resp(imem_resp), .imem_addr(imem_addr), .imem_read(imem_read),
    .line_room(line_room),
    .line_pc(line_pc)
);

// Decode watches the response itself
decode_stage decode_stage_i (
    .clk(clk), .rst_n(rst_n),
    .imem_rdata(imem_rdata), .imem_resp(imem_resp), .line_pc(line_pc),
    .dec_entries(dec_entries), .dec_valid(dec_valid)
);

inst_queue inst_queue_i (
    .clk(clk), .rst_n(rst_n),
    .dec_entries(dec_entries), .dec_valid(dec_valid),
    .issue_pop(issue_pop), .issue_inst(issue_inst), .issue_valid(issue_valid),
    .line_room(line_room)
);

endmodule : front_end

/* dv/front_end_checker.sv */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module front_end_checker (
    input   logic                   clk,
    input   logic                   rst_n,
    input   logic   [31:0]          imem_addr,
    input   logic                   imem_read,
    input   logic                   imem_resp,
    input   logic   [`FE_ISSUE-1:0] issue_valid
);

localparam int LINE_BYTES = `FE_LINE_BITS / 8;
localparam int OFS_W      = $clog2(LINE_BYTES);

// Failure tally, picked up by the testbench at the end of the run
int unsigned fail_count = 0;

// Request level and address frozen until the response
hold_req: assert property (@(posedge clk) disable iff (!rst_n)
    imem_read && !imem_resp |=> imem_read && $stable(imem_addr))
    else begin
        fail_count++;
        $error("imem request dropped or moved before imem_resp");
    end

// Whole lines only
line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    imem_read |-> imem_addr[OFS_W-1:0] == '0)
    else begin
        fail_count++;
        $error("imem_addr 0x%h not line aligned", imem_addr);
    end

// Lane 1 never shows without lane 0
lane_order: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid[1] |-> issue_valid[0])
    else begin
        fail_count++;
        $error("issue_valid lane 1 high while lane 0 low");
    end

// No request in the first cycle out of reset
quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !imem_read)
    else begin
        fail_count++;
        $error("imem_read high in the first cycle after reset");
    end

endmodule : front_end_checker

/* dv/front_end_tb.sv */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module front_end_tb
import frontend_pkg::*;
();

localparam logic [31:0] SEED       = 32'h6d91ebb6;
localparam int          N_INST     = 320;
// Up to 6 latency plus 40 drain cycles for each of 40 lines, rounded up
localparam int          TIMEOUT_CYCLES = 2000;
localparam int          STALL_START    = 200;
localparam int          STALL_END      = 260;
localparam int          LINE_BYTES     = `FE_LINE_BITS / 8;
// The nine RV32I base opcodes
localparam logic [6:0]  LEGAL_OPC [9] = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63,
                                          7'h37, 7'h17, 7'h6f, 7'h67};

logic                       clk;
logic                       rst_n;
logic   [31:0]              imem_addr;
logic                       imem_read;
logic   [`FE_LINE_BITS-1:0] imem_rdata;
logic                       imem_resp;
decoded_inst_t              issue_inst [`FE_ISSUE];
logic   [`FE_ISSUE-1:0]     issue_valid;
logic                       issue_pop;

logic   [31:0]  rng;
int             lat_left;
int             cycle = 0;
int             errors = 0;
int             n_checked = 0;
int             resp_lines = 0;
logic   [31:0]  exp_pc = `FE_RESET_PC;
logic   [31:0]  exp_line = `FE_RESET_PC;
// Expected queue occupancy as seen on the issue lanes
int             exp_count = 0;
// Responses of the last two cycles
logic   [1:0]   resp_hist = '0;

front_end i_dut (.*);

bind front_end front_end_checker checker_i (
    .clk(clk), .rst_n(rst_n),
    .imem_addr(imem_addr), .imem_read(imem_read), .imem_resp(imem_resp),
    .issue_valid(issue_valid)
);

function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Program image hashed from the full word address
function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] w;
    w = xorshift(addr ^ SEED);
    // About one word in four forced to a real opcode
    if (w[9:8] == 2'b00) begin
        w[6:0] = LEGAL_OPC[w[15:12] % 9];
    end
    return w;
endfunction

function automatic logic [`FE_LINE_BITS-1:0] make_line(input logic [31:0] addr);
    logic [`FE_LINE_BITS-1:0] line;
    for (int k = 0; k < `FE_LANES; k++) begin
        line[32*k +: 32] = mem_word(addr + 32'(4 * k));
    end
    return line;
endfunction

// Expected decode straight from the RV32I bit layout
function automatic decoded_inst_t ref_decode(input logic [31:0] pc, input logic [31:0] word);
    decoded_inst_t e;
    e = '0;
    e.pc = pc;
    e.inst = word;
    case (word[6:0])
        7'h33:   e.op_class = OP_REG;
        7'h13:   e.op_class = OP_IMM;
        7'h03:   e.op_class = OP_LOAD;
        7'h23:   e.op_class = OP_STORE;
        7'h63:   e.op_class = OP_BRANCH;
        7'h37:   e.op_class = OP_LUI;
        7'h17:   e.op_class = OP_AUIPC;
        7'h6f:   e.op_class = OP_JAL;
        7'h67:   e.op_class = OP_JALR;
        default: e.op_class = OP_ILLEGAL;
    endcase
    // Register writers
    if (e.op_class inside {OP_REG, OP_IMM, OP_LOAD, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR}) begin
        e.rd = word[11:7];
    end
    if (e.op_class inside {OP_REG, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH, OP_JALR}) begin
        e.rs1 = word[19:15];
    end
    if (e.op_class inside {OP_REG, OP_STORE, OP_BRANCH}) begin
        e.rs2 = word[24:20];
    end
    case (e.op_class)
        OP_IMM, OP_LOAD, OP_JALR: e.imm = {{20{word[31]}}, word[31:20]};
        OP_STORE:  e.imm = {{20{word[31]}}, word[31:25], word[11:7]};
        OP_BRANCH: e.imm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
        OP_LUI, OP_AUIPC: e.imm = {word[31:12], 12'b0};
        OP_JAL:    e.imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
        default:   e.imm = '0;
    endcase
    return e;
endfunction

task automatic check_field(input string name, input int lane,
                           input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        errors++;
        $display("[ERROR] %s lane %0d: got 0x%h expected 0x%h", name, lane, got, exp);
    end
endtask

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

always @(posedge clk) begin
    cycle <= cycle + 1;
end

// Memory model and consumer driven just after each rising edge
initial begin
    rst_n      = 1'b0;
    issue_pop  = 1'b0;
    imem_resp  = 1'b0;
    imem_rdata = '0;
    rng        = SEED;
    lat_left   = 0;
    repeat (16) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    forever begin
        @(posedge clk);
        #0.5;
        // Response is a single-cycle pulse
        imem_resp = 1'b0;
        if (imem_read) begin
            // New request picks its latency
            if (lat_left == 0) begin
                rng = xorshift(rng);
                lat_left = 1 + int'(rng % 6);
            end
            lat_left--;
            if (lat_left == 0) begin
                imem_rdata = make_line(imem_addr);
                imem_resp  = 1'b1;
            end
        end
        rng = xorshift(rng);
        // Pops on roughly 60% of cycles but never inside the stall window
        issue_pop = (cycle < STALL_START || cycle >= STALL_END) && (rng % 100 < 60);
    end
end

// Comparator samples at the falling edge
always @(negedge clk) begin
    decoded_inst_t exp;
    decoded_inst_t got;
    int            outstanding;
    if (rst_n) begin
        if (imem_resp) begin
            check_field("imem_addr", 0, imem_addr, exp_line);
            exp_line = exp_line + LINE_BYTES;
            resp_lines++;
        end
        // A line reaches the issue lanes two cycles after its response
        if (resp_hist[1]) begin
            exp_count = exp_count + `FE_LANES;
        end
        resp_hist = {resp_hist[0], imem_resp};
        // Lane i shows once more than i entries are held
        for (int i = 0; i < `FE_ISSUE; i++) begin
            check_field("issue_valid", i, issue_valid[i], exp_count > i);
        end
        // Pop takes every valid lane in order
        for (int i = 0; i < `FE_ISSUE; i++) begin
            if (issue_pop && issue_valid[i]) begin
                got = issue_inst[i];
                exp = ref_decode(exp_pc, mem_word(exp_pc));
                check_field("pc", i, got.pc, exp.pc);
                check_field("inst", i, got.inst, exp.inst);
                check_field("op_class", i, got.op_class, exp.op_class);
                check_field("rd", i, got.rd, exp.rd);
                check_field("rs1", i, got.rs1, exp.rs1);
                check_field("rs2", i, got.rs2, exp.rs2);
                check_field("imm", i, got.imm, exp.imm);
                exp_pc = exp_pc + 32'd4;
                n_checked++;
                exp_count--;
            end
        end
        // Entries fetched but not yet popped across decode and queue
        outstanding = resp_lines * `FE_LANES - n_checked;
        assert (outstanding <= `FE_IQ_DEPTH) else begin
            errors++;
            $display("Fetched %0d entries beyond what the queue can hold", outstanding);
        end
        // Fetch must have backed off by the last stalled cycle
        if (cycle == STALL_END - 1) begin
            check_field("imem_read", 0, imem_read, 1'b0);
            assert (exp_count > 16) else begin
                errors++;
                $display("Queue held only %0d entries after the consumer stall", exp_count);
            end
        end
    end
end

initial begin
    wait (rst_n);
    while (n_checked < N_INST && cycle < TIMEOUT_CYCLES) begin
        @(posedge clk);
    end
    if (n_checked < N_INST) begin
        errors++;
        $display("Timeout after %0d cycles with %0d of %0d instructions checked",
                 cycle, n_checked, N_INST);
    end
    $display("Checked %0d instructions, %0d errors, %0d assertion failures",
             n_checked, errors, i_dut.checker_i.fail_count);
    if (errors == 0 && i_dut.checker_i.fail_count == 0) begin
        $display("sim passed");
    end else begin
        $display("sim failed");
    end
    $finish;
end

endmodule : front_end_tb

/* vlog.f */
+incdir+hdl
hdl/frontend_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/inst_queue.sv
hdl/front_end.sv
dv/front_end_checker.sv
dv/front_end_tb.sv
